//--- Makefile
# Verilator build and run for the chip pad project

VERILATOR ?= verilator
TOP       ?= tb_chip_pad
RTL_TOP   ?= chip_pad_top
FILELIST  ?= project.f
SIM_DIR   ?= sim_build
LOG       ?= $(SIM_DIR)/sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -Wno-fatal -f $(FILELIST) \
	  --top-module $(TOP) --Mdir $(SIM_DIR) -o $(TOP)

run: build
	./$(SIM_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(SIM_DIR)

//--- hdl/chip_pad_pkg.sv
// chip pad package
// pad counts, MIO pad indices and pad vector types for the GPIO pinout

`default_nettype none

package chip_pad_pkg;

  // pad bus and MIO vector sizes
  localparam int unsigned NGpioPads    = 32;
  localparam int unsigned NMioPads     = 21;
  localparam int unsigned NGenericGpio = 14;
  localparam int unsigned NSwStraps    = 3;
  localparam int unsigned NTapStraps   = 2;

  ////////////////////////////////////////
  // MIO pad indices
  ////////////////////////////////////////

  // generic GPIOs occupy the bottom of the MIO vector
  localparam int unsigned MioGpioBase  = 0;
  localparam int unsigned MioSwStrap0  = 14;
  localparam int unsigned MioTapStrap0 = 17;
  localparam int unsigned MioTapStrap1 = 18;
  localparam int unsigned MioUartRx    = 19;
  localparam int unsigned MioUartTx    = 20;

  ////////////////////////////////////////
  // pad bus positions
  ////////////////////////////////////////

  // sw straps sit on bits 24:22
  localparam int unsigned GpioSwStrapPos   = 22;
  localparam int unsigned GpioTapStrap0Pos = 30;
  localparam int unsigned GpioTapStrap1Pos = 27;

  typedef logic [NGpioPads-1:0]  gpio_bus_t;
  typedef logic [NMioPads-1:0]   mio_vec_t;
  typedef logic [NSwStraps-1:0]  sw_strap_t;
  typedef logic [NTapStraps-1:0] tap_strap_t;

endpackage

`default_nettype wire

//--- hdl/chip_pad_top.sv
// chip pad top
// power-on sequencing chain plus the GPIO and UART pad map

`timescale 1ns/1ps
`default_nettype none

module chip_pad_top (
  input  wire  clk_aon,
  input  wire  rst_n_i,
  input  wire  chip_pad_pkg::gpio_bus_t gpio_p2d_i,
  input  wire  logic uart_rx_p2d_i,
  input  wire  chip_pad_pkg::mio_vec_t core_mio_out_i,
  input  wire  chip_pad_pkg::mio_vec_t core_mio_oe_i,
  input  wire  chip_pad_pkg::mio_vec_t core_pull_en_i,
  input  wire  chip_pad_pkg::mio_vec_t core_pull_sel_i,
  output chip_pad_pkg::mio_vec_t   core_mio_in_o,
  output chip_pad_pkg::gpio_bus_t  gpio_d2p_o,
  output chip_pad_pkg::gpio_bus_t  gpio_en_d2p_o,
  output chip_pad_pkg::gpio_bus_t  gpio_pull_en_o,
  output chip_pad_pkg::gpio_bus_t  gpio_pull_select_o,
  output logic uart_tx_d2p_o,
  output logic uart_tx_en_d2p_o,
  output logic por_n_o,
  output chip_pad_pkg::sw_strap_t  sw_strap_o,
  output chip_pad_pkg::tap_strap_t tap_strap_o
);

  import chip_pad_pkg::*;

  logic       vcc_supp;
  logic       pok;
  logic       strap_sample;
  logic       core_rst_n;
  sw_strap_t  sw_raw;
  tap_strap_t tap_raw;

  ////////////////////////////////////////
  // power-on sequencing
  ////////////////////////////////////////

  supply_ramp u_supply_ramp (
    .clk_aon    (clk_aon),
    .rst_n_i    (rst_n_i),
    .vcc_supp_o (vcc_supp)
  );

  pok_filter u_pok_filter (
    .clk_aon    (clk_aon),
    .rst_n_i    (rst_n_i),
    .vcc_supp_i (vcc_supp),
    .pok_o      (pok)
  );

  por_fsm u_por_fsm (
    .clk_aon        (clk_aon),
    .rst_n_i        (rst_n_i),
    .pok_i          (pok),
    .strap_sample_o (strap_sample),
    .core_rst_n_o   (core_rst_n)
  );

  assign por_n_o = core_rst_n;

  strap_latch u_strap_latch (
    .clk_aon        (clk_aon),
    .rst_n_i        (rst_n_i),
    .strap_sample_i (strap_sample),
    .sw_raw_i       (sw_raw),
    .tap_raw_i      (tap_raw),
    .sw_strap_o     (sw_strap_o),
    .tap_strap_o    (tap_strap_o)
  );

  // pads
  gpio_pad_map u_gpio_pad_map (
    .clk_aon            (clk_aon),
    .rst_n_i            (rst_n_i),
    .core_rst_n_i       (core_rst_n),
    .gpio_p2d_i         (gpio_p2d_i),
    .uart_rx_p2d_i      (uart_rx_p2d_i),
    .core_mio_out_i     (core_mio_out_i),
    .core_mio_oe_i      (core_mio_oe_i),
    .core_pull_en_i     (core_pull_en_i),
    .core_pull_sel_i    (core_pull_sel_i),
    .core_mio_in_o      (core_mio_in_o),
    .sw_raw_o           (sw_raw),
    .tap_raw_o          (tap_raw),
    .gpio_d2p_o         (gpio_d2p_o),
    .gpio_en_d2p_o      (gpio_en_d2p_o),
    .gpio_pull_en_o     (gpio_pull_en_o),
    .gpio_pull_select_o (gpio_pull_select_o),
    .uart_tx_d2p_o      (uart_tx_d2p_o),
    .uart_tx_en_d2p_o   (uart_tx_en_d2p_o)
  );

endmodule

`default_nettype wire

//--- hdl/gpio_pad_map.sv
// GPIO pad map
// gathers pad bus inputs into the MIO vector and scatters MIO outputs
// and pull attributes back onto the pad buses

`timescale 1ns/1ps
`default_nettype none

module gpio_pad_map (
  input  wire  clk_aon,
  input  wire  rst_n_i,
  input  wire  logic core_rst_n_i,
  input  wire  chip_pad_pkg::gpio_bus_t gpio_p2d_i,
  input  wire  logic uart_rx_p2d_i,
  input  wire  chip_pad_pkg::mio_vec_t core_mio_out_i,
  input  wire  chip_pad_pkg::mio_vec_t core_mio_oe_i,
  input  wire  chip_pad_pkg::mio_vec_t core_pull_en_i,
  input  wire  chip_pad_pkg::mio_vec_t core_pull_sel_i,
  output chip_pad_pkg::mio_vec_t   core_mio_in_o,
  output chip_pad_pkg::sw_strap_t  sw_raw_o,
  output chip_pad_pkg::tap_strap_t tap_raw_o,
  output chip_pad_pkg::gpio_bus_t  gpio_d2p_o,
  output chip_pad_pkg::gpio_bus_t  gpio_en_d2p_o,
  output chip_pad_pkg::gpio_bus_t  gpio_pull_en_o,
  output chip_pad_pkg::gpio_bus_t  gpio_pull_select_o,
  output logic uart_tx_d2p_o,
  output logic uart_tx_en_d2p_o
);

  import chip_pad_pkg::*;

  mio_vec_t sync1_q;
  mio_vec_t sync2_q;

  // pad bus to MIO order, pads without a bus bit read 0
  function automatic mio_vec_t gather(input gpio_bus_t bus, input logic rx);
    mio_vec_t v;
    v = '0;
    v[MioGpioBase +: NGenericGpio] = bus[NGenericGpio-1:0];
    v[MioSwStrap0 +: NSwStraps]    = bus[GpioSwStrapPos +: NSwStraps];
    v[MioTapStrap0]                = bus[GpioTapStrap0Pos];
    v[MioTapStrap1]                = bus[GpioTapStrap1Pos];
    v[MioUartRx]                   = rx;
    return v;
  endfunction

  // MIO order to pad bus, unused bus bits tied low
  function automatic gpio_bus_t scatter(input mio_vec_t v);
    gpio_bus_t bus;
    bus = '0;
    bus[NGenericGpio-1:0]           = v[MioGpioBase +: NGenericGpio];
    bus[GpioSwStrapPos +: NSwStraps] = v[MioSwStrap0 +: NSwStraps];
    bus[GpioTapStrap0Pos]           = v[MioTapStrap0];
    bus[GpioTapStrap1Pos]           = v[MioTapStrap1];
    return bus;
  endfunction

  ////////////////////////////////////////
  // input path, two-flop synchronizer
  ////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= gather(gpio_p2d_i, uart_rx_p2d_i);
      sync2_q <= sync1_q;
    end
  end

  assign core_mio_in_o = sync2_q;
  assign sw_raw_o      = sync2_q[MioSwStrap0 +: NSwStraps];
  assign tap_raw_o     = {sync2_q[MioTapStrap1], sync2_q[MioTapStrap0]};

  ////////////////////////////////////////
  // output path, held off until core reset release
  ////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i || !core_rst_n_i) begin
      gpio_d2p_o         <= '0;
      gpio_en_d2p_o      <= '0;
      gpio_pull_en_o     <= '0;
      gpio_pull_select_o <= '0;
      uart_tx_d2p_o      <= 1'b0;
      uart_tx_en_d2p_o   <= 1'b0;
    end else begin
      gpio_d2p_o         <= scatter(core_mio_out_i);
      gpio_en_d2p_o      <= scatter(core_mio_oe_i);
      // pull attributes keep the same bit order as the data
      gpio_pull_en_o     <= scatter(core_pull_en_i);
      gpio_pull_select_o <= scatter(core_pull_sel_i);
      uart_tx_d2p_o      <= core_mio_out_i[MioUartTx];
      uart_tx_en_d2p_o   <= core_mio_oe_i[MioUartTx];
    end
  end

endmodule

`default_nettype wire

//--- hdl/pok_filter.sv
// power-ok filter
// asserts a sticky power-ok once the supply has stayed high long enough

`timescale 1ns/1ps
`default_nettype none

module pok_filter (
  input  wire  clk_aon,
  input  wire  rst_n_i,
  input  wire  logic vcc_supp_i,
  output logic pok_o
);

  import por_pkg::*;

  pok_cnt_t hold_cnt_q;

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      hold_cnt_q <= '0;
      pok_o      <= 1'b0;
    end else begin
      // any low cycle restarts the hold window
      if (!vcc_supp_i) begin
        hold_cnt_q <= '0;
      end else if (hold_cnt_q != PokHoldCycles) begin
        hold_cnt_q <= hold_cnt_q + pok_cnt_t'(1);
      end
      // last cycle of the window sets the flag, kept until reset
      if (vcc_supp_i && (hold_cnt_q == PokHoldCycles - pok_cnt_t'(1))) begin
        pok_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/por_fsm.sv
// power-on sequencer
// waits for power-ok, samples the straps once, then releases core reset

`timescale 1ns/1ps
`default_nettype none

module por_fsm (
  input  wire  clk_aon,
  input  wire  rst_n_i,
  input  wire  logic pok_i,
  output logic strap_sample_o,
  output logic core_rst_n_o
);

  import por_pkg::*;

  por_state_t state_q;
  por_state_t state_d;

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      PorOff:          state_d = PorWaitPok;
      PorWaitPok: begin
        if (pok_i) begin
          state_d = PorSampleStraps;
        end
      end
      // single cycle, straps are taken here
      PorSampleStraps: state_d = PorRun;
      PorRun:          state_d = PorRun;
      default:         state_d = PorOff;
    endcase
  end

  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      state_q <= PorOff;
    end else begin
      state_q <= state_d;
    end
  end

  // outputs straight from the state register
  assign strap_sample_o = (state_q == PorSampleStraps);
  assign core_rst_n_o   = (state_q == PorRun);

endmodule

`default_nettype wire

//--- hdl/por_pkg.sv
// power-on package
// supply emulation windows, power-ok hold time and sequencer state

`default_nettype none

package por_pkg;

  typedef logic [3:0] supply_cnt_t;
  typedef logic [2:0] pok_cnt_t;

  // emulated supply: low, glitch high, low again, then stable high
  localparam supply_cnt_t SupplyCntMax   = 4'd15;
  localparam supply_cnt_t SupplyLowEnd1  = 4'd4;
  localparam supply_cnt_t SupplyHighEnd1 = 4'd8;
  localparam supply_cnt_t SupplyLowEnd2  = 4'd12;

  // consecutive high cycles before power-ok, longer than the glitch
  localparam pok_cnt_t PokHoldCycles = 3'd6;

  typedef enum logic [1:0] {
    PorOff,
    PorWaitPok,
    PorSampleStraps,
    PorRun
  } por_state_t;

endpackage

`default_nettype wire

//--- hdl/strap_latch.sv
// strap latch
// captures software and TAP straps on the sample pulse and holds them

`timescale 1ns/1ps
`default_nettype none

module strap_latch (
  input  wire  clk_aon,
  input  wire  rst_n_i,
  input  wire  logic strap_sample_i,
  input  wire  chip_pad_pkg::sw_strap_t  sw_raw_i,
  input  wire  chip_pad_pkg::tap_strap_t tap_raw_i,
  output chip_pad_pkg::sw_strap_t  sw_strap_o,
  output chip_pad_pkg::tap_strap_t tap_strap_o
);

  // sampled once per power-on, later strap pin activity is ignored
  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      sw_strap_o  <= '0;
      tap_strap_o <= '0;
    end else if (strap_sample_i) begin
      sw_strap_o  <= sw_raw_i;
      tap_strap_o <= tap_raw_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/supply_ramp.sv
// supply ramp emulation
// saturating counter that fakes a supply which glitches low before settling

`timescale 1ns/1ps
`default_nettype none

module supply_ramp (
  input  wire  clk_aon,
  input  wire  rst_n_i,
  output logic vcc_supp_o
);

  import por_pkg::*;

  supply_cnt_t cnt_q;

  // count up once per cycle and stop at the top
  always_ff @(posedge clk_aon) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q < SupplyCntMax) begin
      cnt_q <= cnt_q + supply_cnt_t'(1);
    end
  end

  // high during the glitch window and again from the second low end on
  always_comb begin
    vcc_supp_o = ((cnt_q >= SupplyLowEnd1) && (cnt_q < SupplyHighEnd1)) ||
                 (cnt_q >= SupplyLowEnd2);
  end

endmodule

`default_nettype wire

//--- project.f
hdl/chip_pad_pkg.sv
hdl/por_pkg.sv
hdl/supply_ramp.sv
hdl/pok_filter.sv
hdl/por_fsm.sv
hdl/strap_latch.sv
hdl/gpio_pad_map.sv
hdl/chip_pad_top.sv
verif/chip_pad_checker.sv
verif/tb_chip_pad.sv

//--- verif/chip_pad_checker.sv
// chip pad checker
// watches the power-on release and compares pad, strap and MIO outputs

`timescale 1ns/1ps
`default_nettype none

module chip_pad_checker (
  input  wire  clk_aon,
  input  wire  rst_n_i,
  input  wire  logic chk_stb_i,
  input  wire  chip_pad_pkg::gpio_bus_t  exp_d2p_i,
  input  wire  chip_pad_pkg::gpio_bus_t  exp_en_i,
  input  wire  chip_pad_pkg::gpio_bus_t  exp_pull_en_i,
  input  wire  chip_pad_pkg::gpio_bus_t  exp_pull_sel_i,
  input  wire  chip_pad_pkg::mio_vec_t   exp_mio_in_i,
  input  wire  logic exp_uart_tx_i,
  input  wire  logic exp_uart_en_i,
  input  wire  chip_pad_pkg::sw_strap_t  exp_sw_i,
  input  wire  chip_pad_pkg::tap_strap_t exp_tap_i,
  input  wire  logic por_n_i,
  input  wire  chip_pad_pkg::mio_vec_t   mio_in_i,
  input  wire  chip_pad_pkg::gpio_bus_t  d2p_i,
  input  wire  chip_pad_pkg::gpio_bus_t  en_d2p_i,
  input  wire  chip_pad_pkg::gpio_bus_t  pull_en_i,
  input  wire  chip_pad_pkg::gpio_bus_t  pull_sel_i,
  input  wire  logic uart_tx_i,
  input  wire  logic uart_tx_en_i,
  input  wire  chip_pad_pkg::sw_strap_t  sw_strap_i,
  input  wire  chip_pad_pkg::tap_strap_t tap_strap_i,
  output int unsigned err_cnt_o,
  output int unsigned chk_cnt_o
);

  import chip_pad_pkg::*;

  // release window in cycles after reset deassertion
  localparam int unsigned PorMinCycles = 16;
  localparam int unsigned PorMaxCycles = 24;

  int unsigned cyc_q;
  logic        released_q;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    chk_cnt_o++;
    if (got !== exp) begin
      err_cnt_o++;
      $display("FAIL %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  always @(posedge clk_aon) begin
    if (!rst_n_i) begin
      cyc_q      = 0;
      released_q = 1'b0;
    end else begin
      if (!released_q && por_n_i === 1'b1) begin
        released_q = 1'b1;
        chk_cnt_o++;
        if (cyc_q < PorMinCycles || cyc_q > PorMaxCycles) begin
          err_cnt_o++;
          $display("por_n_o released %0d cycles after reset, outside %0d to %0d",
                   cyc_q, PorMinCycles, PorMaxCycles);
        end
      end else if (released_q && por_n_i !== 1'b1) begin
        err_cnt_o++;
        $display("por_n_o dropped again after the core reset was released at %0t", $time);
      end
      // pads stay quiet while the core is held in reset
      if (!released_q) begin
        compare_value("gpio_d2p_o", d2p_i, '0);
        compare_value("gpio_en_d2p_o", en_d2p_i, '0);
        compare_value("gpio_pull_en_o", pull_en_i, '0);
        compare_value("gpio_pull_select_o", pull_sel_i, '0);
        compare_value("uart_tx_d2p_o", 32'(uart_tx_i), '0);
        compare_value("uart_tx_en_d2p_o", 32'(uart_tx_en_i), '0);
      end
      if (chk_stb_i) begin
        compare_value("gpio_d2p_o", d2p_i, exp_d2p_i);
        compare_value("gpio_en_d2p_o", en_d2p_i, exp_en_i);
        compare_value("gpio_pull_en_o", pull_en_i, exp_pull_en_i);
        compare_value("gpio_pull_select_o", pull_sel_i, exp_pull_sel_i);
        compare_value("core_mio_in_o", 32'(mio_in_i), 32'(exp_mio_in_i));
        compare_value("uart_tx_d2p_o", 32'(uart_tx_i), 32'(exp_uart_tx_i));
        compare_value("uart_tx_en_d2p_o", 32'(uart_tx_en_i), 32'(exp_uart_en_i));
        compare_value("sw_strap_o", 32'(sw_strap_i), 32'(exp_sw_i));
        compare_value("tap_strap_o", 32'(tap_strap_i), 32'(exp_tap_i));
      end
      cyc_q = cyc_q + 1;
    end
  end

endmodule

`default_nettype wire

//--- verif/chip_pad_testdata.txt
// gpio_p2d uart_rx core_out core_oe core_pull_en core_pull_sel (hex)
// then expected gpio_d2p gpio_en_d2p gpio_pull_en gpio_pull_select (hex)
00000000 0 000000 000000 000000 000000 00000000 00000000 00000000 00000000
ffffffff 1 1fffff 1fffff 1fffff 1fffff 49c03fff 49c03fff 49c03fff 49c03fff
49c03fff 0 003fff 01c000 020000 040000 00003fff 01c00000 40000000 08000000
00003fff 1 01c000 020000 040000 003fff 01c00000 40000000 08000000 00003fff
01c00000 0 020000 040000 003fff 01c000 40000000 08000000 00003fff 01c00000
40000000 1 040000 003fff 01c000 020000 08000000 00003fff 01c00000 40000000
08000000 0 180000 100000 080000 180000 00000000 00000000 00000000 00000000
00000001 1 000001 002000 004000 010000 00000001 00002000 00400000 01000000
40802aaa 0 0aaaaa 155555 0aaaaa 155555 40802aaa 09401555 40802aaa 09401555
09401555 1 155555 0aaaaa 155555 0aaaaa 09401555 40802aaa 09401555 40802aaa
b63fc000 0 100000 100000 000000 1fffff 00000000 00000000 00000000 49c03fff
01000000 1 080000 180000 1fffff 000000 00000000 00000000 49c03fff 00000000

//--- verif/tb_chip_pad.sv
// chip pad testbench
// clock, reset, strap setup and file-driven pad vectors with a closing report

`timescale 1ns/1ps
`default_nettype none

module tb_chip_pad;

  import chip_pad_pkg::*;

  localparam int unsigned NVectors     = 12;
  localparam int unsigned NWords       = 10;
  localparam int unsigned PorMaxCycles = 24;
  // pad bus bits that carry an MIO pad
  localparam logic [31:0] MappedMask   = 32'h49c0_3fff;

  logic       clk_aon;
  logic       rst_n_i;
  gpio_bus_t  gpio_p2d_i;
  logic       uart_rx_p2d_i;
  mio_vec_t   core_mio_out_i;
  mio_vec_t   core_mio_oe_i;
  mio_vec_t   core_pull_en_i;
  mio_vec_t   core_pull_sel_i;
  mio_vec_t   core_mio_in_o;
  gpio_bus_t  gpio_d2p_o;
  gpio_bus_t  gpio_en_d2p_o;
  gpio_bus_t  gpio_pull_en_o;
  gpio_bus_t  gpio_pull_select_o;
  logic       uart_tx_d2p_o;
  logic       uart_tx_en_d2p_o;
  logic       por_n_o;
  sw_strap_t  sw_strap_o;
  tap_strap_t tap_strap_o;

  // expectations handed to the checker
  logic       chk_stb;
  gpio_bus_t  exp_d2p;
  gpio_bus_t  exp_en;
  gpio_bus_t  exp_pull_en;
  gpio_bus_t  exp_pull_sel;
  mio_vec_t   exp_mio_in;
  logic       exp_uart_tx;
  logic       exp_uart_en;
  sw_strap_t  exp_sw;
  tap_strap_t exp_tap;

  int unsigned err_cnt;
  int unsigned chk_cnt;
  logic [31:0] vec_mem [0:NVectors*NWords-1];
  logic [31:0] rng_state;

  chip_pad_top DUT (
    .clk_aon            (clk_aon),
    .rst_n_i            (rst_n_i),
    .gpio_p2d_i         (gpio_p2d_i),
    .uart_rx_p2d_i      (uart_rx_p2d_i),
    .core_mio_out_i     (core_mio_out_i),
    .core_mio_oe_i      (core_mio_oe_i),
    .core_pull_en_i     (core_pull_en_i),
    .core_pull_sel_i    (core_pull_sel_i),
    .core_mio_in_o      (core_mio_in_o),
    .gpio_d2p_o         (gpio_d2p_o),
    .gpio_en_d2p_o      (gpio_en_d2p_o),
    .gpio_pull_en_o     (gpio_pull_en_o),
    .gpio_pull_select_o (gpio_pull_select_o),
    .uart_tx_d2p_o      (uart_tx_d2p_o),
    .uart_tx_en_d2p_o   (uart_tx_en_d2p_o),
    .por_n_o            (por_n_o),
    .sw_strap_o         (sw_strap_o),
    .tap_strap_o        (tap_strap_o)
  );

  chip_pad_checker u_checker (
    .clk_aon        (clk_aon),
    .rst_n_i        (rst_n_i),
    .chk_stb_i      (chk_stb),
    .exp_d2p_i      (exp_d2p),
    .exp_en_i       (exp_en),
    .exp_pull_en_i  (exp_pull_en),
    .exp_pull_sel_i (exp_pull_sel),
    .exp_mio_in_i   (exp_mio_in),
    .exp_uart_tx_i  (exp_uart_tx),
    .exp_uart_en_i  (exp_uart_en),
    .exp_sw_i       (exp_sw),
    .exp_tap_i      (exp_tap),
    .por_n_i        (por_n_o),
    .mio_in_i       (core_mio_in_o),
    .d2p_i          (gpio_d2p_o),
    .en_d2p_i       (gpio_en_d2p_o),
    .pull_en_i      (gpio_pull_en_o),
    .pull_sel_i     (gpio_pull_select_o),
    .uart_tx_i      (uart_tx_d2p_o),
    .uart_tx_en_i   (uart_tx_en_d2p_o),
    .sw_strap_i     (sw_strap_o),
    .tap_strap_i    (tap_strap_o),
    .err_cnt_o      (err_cnt),
    .chk_cnt_o      (chk_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // pad bus to MIO order following the pinout table
  function automatic mio_vec_t expected_mio_in(input gpio_bus_t bus, input logic rx);
    mio_vec_t v;
    v = '0;
    for (int i = 0; i < 14; i++) begin
      v[i] = bus[i];
    end
    v[16:14] = bus[24:22];
    v[17]    = bus[30];
    v[18]    = bus[27];
    v[19]    = rx;
    return v;
  endfunction

  function automatic gpio_bus_t strap_pads(input sw_strap_t sw, input tap_strap_t tap);
    gpio_bus_t bus;
    bus        = '0;
    bus[24:22] = sw;
    bus[30]    = tap[0];
    bus[27]    = tap[1];
    return bus;
  endfunction

  ////////////////////////////////////////
  // vector application
  ////////////////////////////////////////

  task automatic apply_vector(input int unsigned idx);
    int unsigned base;
    gpio_bus_t   pad_val;
    base      = idx * NWords;
    rng_state = xorshift32(rng_state);
    // noise on the unmapped bits must not matter
    pad_val   = (vec_mem[base] & MappedMask) | (rng_state & ~MappedMask);
    @(posedge clk_aon);
    gpio_p2d_i      <= pad_val;
    uart_rx_p2d_i   <= vec_mem[base+1][0];
    core_mio_out_i  <= mio_vec_t'(vec_mem[base+2]);
    core_mio_oe_i   <= mio_vec_t'(vec_mem[base+3]);
    core_pull_en_i  <= mio_vec_t'(vec_mem[base+4]);
    core_pull_sel_i <= mio_vec_t'(vec_mem[base+5]);
    repeat (3) @(posedge clk_aon);
    exp_d2p      <= vec_mem[base+6];
    exp_en       <= vec_mem[base+7];
    exp_pull_en  <= vec_mem[base+8];
    exp_pull_sel <= vec_mem[base+9];
    exp_mio_in   <= expected_mio_in(pad_val, vec_mem[base+1][0]);
    exp_uart_tx  <= vec_mem[base+2][MioUartTx];
    exp_uart_en  <= vec_mem[base+3][MioUartTx];
    chk_stb      <= 1'b1;
    @(posedge clk_aon);
    chk_stb      <= 1'b0;
  endtask

  initial begin
    clk_aon = 1'b0;
    forever #2 clk_aon = ~clk_aon;
  end

  initial begin
    int unsigned wait_cnt;
    rst_n_i         = 1'b0;
    uart_rx_p2d_i   = 1'b0;
    // core side fully active during power-on, pads must still stay quiet
    core_mio_out_i  = '1;
    core_mio_oe_i   = '1;
    core_pull_en_i  = '1;
    core_pull_sel_i = '1;
    chk_stb         = 1'b0;
    exp_d2p         = '0;
    exp_en          = '0;
    exp_pull_en     = '0;
    exp_pull_sel    = '0;
    exp_mio_in      = '0;
    exp_uart_tx     = 1'b0;
    exp_uart_en     = 1'b0;
    exp_sw          = 3'b101;
    exp_tap         = 2'b01;
    rng_state       = 32'hdd5dabe9;
    $readmemh("verif/chip_pad_testdata.txt", vec_mem);
    // straps are on the pads from the start
    rng_state  = xorshift32(rng_state);
    gpio_p2d_i = strap_pads(exp_sw, exp_tap) | (rng_state & ~MappedMask);

    repeat (5) @(posedge clk_aon);
    rst_n_i <= 1'b1;

    wait_cnt = 0;
    while (por_n_o !== 1'b1 && wait_cnt <= PorMaxCycles) begin
      @(negedge clk_aon);
      wait_cnt++;
    end

    if (por_n_o !== 1'b1) begin
      $display("timeout: por_n_o was not released within %0d cycles of reset", PorMaxCycles);
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      $display("Simulation FAILED");
    end else begin
      for (int unsigned i = 0; i < NVectors; i++) begin
        apply_vector(i);
      end
      repeat (2) @(posedge clk_aon);
      @(negedge clk_aon);
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire
